// ==== Bender.yml ====
package:
  name: squash_unit

sources:
  - common/seq_pkg.sv
  - common/squash_pkg.sv
  - common/squash_notif_if.sv
  - src/commit_tracker.sv
  - squash/squash_arb_chain.sv
  - squash/squash_fsm.sv
  - src/squash_unit.sv
  - target: test
    files:
      - tests/tb_clock_gen.sv
      - tests/squash_unit_tb.sv

// ==== common/seq_pkg.sv ====
//----------------------------------------------------------
// Sequence number width and wrap-aware age comparison.
// Import into any block that orders instructions by age.
//----------------------------------------------------------

package seq_pkg;

  //----------------------------------------------------------
  // Sequence numbers
  //----------------------------------------------------------

  // Window of 64 instructions in flight
  localparam int SEQ_NUM_BITS = 6;

  //----------------------------------------------------------
  // Age comparison
  //----------------------------------------------------------

  // True when seq_a is older than seq_b
  // Both are measured as a distance from the oldest in flight,
  // so numbers that wrap past the top still order correctly
  function automatic logic seq_is_older(
    input logic [SEQ_NUM_BITS-1:0] seq_a,
    input logic [SEQ_NUM_BITS-1:0] seq_b,
    input logic [SEQ_NUM_BITS-1:0] head
  );
    logic [SEQ_NUM_BITS-1:0] dist_a;
    logic [SEQ_NUM_BITS-1:0] dist_b;
    // Subtraction wraps modulo the window size
    dist_a = seq_a - head;
    dist_b = seq_b - head;
    return (dist_a < dist_b);
  endfunction

endpackage

// ==== common/squash_notif_if.sv ====
//----------------------------------------------------------
// One squash notification: valid strobe, sequence number,
// redirect target and cause. Publisher drives, subscriber
// samples.
//----------------------------------------------------------

interface squash_notif_if
  import seq_pkg::*, squash_pkg::*;
();

  // Notification counts only while val is high
  logic                    val;
  logic [SEQ_NUM_BITS-1:0] seq_num;
  logic [TARGET_BITS-1:0]  target;
  logic [CAUSE_BITS-1:0]   cause;

  // Source side
  modport pub (
    output val,
    output seq_num,
    output target,
    output cause
  );

  // Consumer side
  modport sub (
    input val,
    input seq_num,
    input target,
    input cause
  );

endinterface

// ==== common/squash_pkg.sv ====
//----------------------------------------------------------
// Squash notification constants: source count, redirect
// target width and cause codes.
//----------------------------------------------------------

package squash_pkg;

  //----------------------------------------------------------
  // Sources and field widths
  //----------------------------------------------------------

  // Two branch units plus the load-store unit
  localparam int NUM_SQUASH_SRC = 3;

  // Redirect target is a full address
  localparam int TARGET_BITS = 32;

  // Cause field
  localparam int CAUSE_BITS = 2;

  //----------------------------------------------------------
  // Cause codes
  //----------------------------------------------------------

  // Branch misprediction
  localparam logic [CAUSE_BITS-1:0] CAUSE_BRANCH = 2'b01;

  // Memory ordering violation from the load-store unit
  localparam logic [CAUSE_BITS-1:0] CAUSE_MEM_ORDER = 2'b10;

endpackage

// ==== project.f ====
common/seq_pkg.sv
common/squash_pkg.sv
common/squash_notif_if.sv
src/commit_tracker.sv
squash/squash_arb_chain.sv
squash/squash_fsm.sv
src/squash_unit.sv
tests/tb_clock_gen.sv
tests/squash_unit_tb.sv

// ==== squash/squash_arb_chain.sv ====
//----------------------------------------------------------
// Combinational chain arbiter. Picks the oldest valid squash
// notification relative to head. Ties go to the lowest
// source index. No state, zero cycles from input to grant.
//----------------------------------------------------------

module squash_arb_chain
  import seq_pkg::*, squash_pkg::*;
(
  //----------------------------------------------------------
  // Notifications from the execution sources
  //----------------------------------------------------------

  squash_notif_if.sub arb [NUM_SQUASH_SRC],

  //----------------------------------------------------------
  // Oldest valid notification
  //----------------------------------------------------------

  squash_notif_if.pub gnt,

  // Oldest uncommitted sequence number, for age compare
  input logic [SEQ_NUM_BITS-1:0] head
);

  //----------------------------------------------------------
  // Chain state
  //----------------------------------------------------------

  // Best candidate carried out of each stage
  logic                    carry_val     [NUM_SQUASH_SRC];
  logic [SEQ_NUM_BITS-1:0] carry_seq_num [NUM_SQUASH_SRC];
  logic [TARGET_BITS-1:0]  carry_target  [NUM_SQUASH_SRC];
  logic [CAUSE_BITS-1:0]   carry_cause   [NUM_SQUASH_SRC];

  // First stage simply takes source 0
  assign carry_val[0]     = arb[0].val;
  assign carry_seq_num[0] = arb[0].seq_num;
  assign carry_target[0]  = arb[0].target;
  assign carry_cause[0]   = arb[0].cause;

  //----------------------------------------------------------
  // Chain stages
  //----------------------------------------------------------

  genvar i;

  generate
    for (i = 1; i < NUM_SQUASH_SRC; i = i + 1) begin : g_stage
      // Stage replaces the carried candidate
      logic take;

      // Strictly older wins, so on equal age the earlier one stays
      assign take = arb[i].val &
                    (!carry_val[i-1] |
                     seq_is_older(arb[i].seq_num, carry_seq_num[i-1], head));

      assign carry_val[i]     = take ? 1'b1           : carry_val[i-1];
      assign carry_seq_num[i] = take ? arb[i].seq_num : carry_seq_num[i-1];
      assign carry_target[i]  = take ? arb[i].target  : carry_target[i-1];
      assign carry_cause[i]   = take ? arb[i].cause   : carry_cause[i-1];
    end
  endgenerate

  //----------------------------------------------------------
  // Grant
  //----------------------------------------------------------

  // Last stage holds the overall winner
  assign gnt.val     = carry_val[NUM_SQUASH_SRC-1];
  assign gnt.seq_num = carry_seq_num[NUM_SQUASH_SRC-1];
  assign gnt.target  = carry_target[NUM_SQUASH_SRC-1];
  assign gnt.cause   = carry_cause[NUM_SQUASH_SRC-1];

endmodule

// ==== squash/squash_fsm.sv ====
//----------------------------------------------------------
// Squash state machine. Registers the granted squash,
// pulses the redirect for one cycle and stays busy until
// the squashing instruction commits. While busy, only an
// older squash is taken.
//----------------------------------------------------------

module squash_fsm
  import seq_pkg::*, squash_pkg::*;
(
  input  logic                    clk,
  input  logic                    reset,

  // Winner from the arbiter
  squash_notif_if.sub             gnt,

  // Oldest uncommitted sequence number
  input  logic [SEQ_NUM_BITS-1:0] head,

  // Commit notifications
  input  logic                    commit_val,
  input  logic [SEQ_NUM_BITS-1:0] commit_seq_num,

  //----------------------------------------------------------
  // Redirect toward the front end
  //----------------------------------------------------------

  output logic                    redirect_val,
  output logic [SEQ_NUM_BITS-1:0] redirect_seq_num,
  output logic [TARGET_BITS-1:0]  redirect_target,
  output logic [CAUSE_BITS-1:0]   redirect_cause,

  // High while a squash is draining
  output logic                    squash_busy
);

  //----------------------------------------------------------
  // State
  //----------------------------------------------------------

  // Low is idle, high is drain
  logic                    draining;

  // Held squash
  logic [SEQ_NUM_BITS-1:0] held_seq_num;
  logic [TARGET_BITS-1:0]  held_target;
  logic [CAUSE_BITS-1:0]   held_cause;

  // Winner taken this cycle
  logic                    accept;

  // Held instruction commits this cycle
  logic                    held_commit;

  //----------------------------------------------------------
  // Acceptance and drain exit
  //----------------------------------------------------------

  // From idle anything goes; in drain only an older squash
  assign accept = gnt.val &
                  (!draining | seq_is_older(gnt.seq_num, held_seq_num, head));

  assign held_commit = draining & commit_val & (commit_seq_num == held_seq_num);

  //----------------------------------------------------------
  // Control registers
  //----------------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      draining     <= 1'b0;
      redirect_val <= 1'b0;
    end else begin
      // One redirect pulse per acceptance
      redirect_val <= accept;
      // Acceptance beats a same-cycle commit
      if (accept) begin
        draining <= 1'b1;
      end else if (held_commit) begin
        draining <= 1'b0;
      end
    end
  end

  //----------------------------------------------------------
  // Held payload
  //----------------------------------------------------------

  always_ff @(posedge clk) begin
    if (accept) begin
      held_seq_num <= gnt.seq_num;
      held_target  <= gnt.target;
      held_cause   <= gnt.cause;
    end
  end

  //----------------------------------------------------------
  // Outputs
  //----------------------------------------------------------

  // Payload stays up until the next acceptance
  assign redirect_seq_num = held_seq_num;
  assign redirect_target  = held_target;
  assign redirect_cause   = held_cause;

  // Rises together with the redirect pulse
  assign squash_busy = draining;

endmodule

// ==== src/commit_tracker.sv ====
//----------------------------------------------------------
// Head pointer for age comparison. Holds the oldest
// uncommitted sequence number, moved past each commit.
//----------------------------------------------------------

module commit_tracker
  import seq_pkg::*;
(
  input  logic                    clk,
  input  logic                    reset,

  // Commit strobe and the committed sequence number
  input  logic                    commit_val,
  input  logic [SEQ_NUM_BITS-1:0] commit_seq_num,

  // Oldest in flight
  output logic [SEQ_NUM_BITS-1:0] head
);

  //----------------------------------------------------------
  // Head register
  //----------------------------------------------------------

  // Next instruction after the one that just committed
  logic [SEQ_NUM_BITS-1:0] next_head;

  // Wraps at the top of the window
  assign next_head = commit_seq_num + 1'b1;

  always_ff @(posedge clk) begin
    if (reset) begin
      head <= '0;
    end else if (commit_val) begin
      head <= next_head;
    end
  end

endmodule

// ==== src/squash_unit.sv ====
//----------------------------------------------------------
// Squash unit top level. Bundles each source into a
// notification interface and wires the head tracker, the
// oldest-first arbiter and the squash state machine.
//----------------------------------------------------------

module squash_unit
  import seq_pkg::*, squash_pkg::*;
(
  input  logic                    clk,
  input  logic                    reset,

  //----------------------------------------------------------
  // Squash sources
  //----------------------------------------------------------

  input  logic                    src_val     [NUM_SQUASH_SRC],
  input  logic [SEQ_NUM_BITS-1:0] src_seq_num [NUM_SQUASH_SRC],
  input  logic [TARGET_BITS-1:0]  src_target  [NUM_SQUASH_SRC],
  input  logic [CAUSE_BITS-1:0]   src_cause   [NUM_SQUASH_SRC],

  // Commit notifications
  input  logic                    commit_val,
  input  logic [SEQ_NUM_BITS-1:0] commit_seq_num,

  //----------------------------------------------------------
  // Redirect and status
  //----------------------------------------------------------

  output logic                    redirect_val,
  output logic [SEQ_NUM_BITS-1:0] redirect_seq_num,
  output logic [TARGET_BITS-1:0]  redirect_target,
  output logic [CAUSE_BITS-1:0]   redirect_cause,
  output logic                    squash_busy
);

  // Oldest uncommitted sequence number
  logic [SEQ_NUM_BITS-1:0] head;

  // One bundle per source, one for the winner
  squash_notif_if src_if [NUM_SQUASH_SRC] ();
  squash_notif_if gnt_if ();

  //----------------------------------------------------------
  // Source bundling
  //----------------------------------------------------------

  genvar g;

  generate
    for (g = 0; g < NUM_SQUASH_SRC; g = g + 1) begin : g_src
      assign src_if[g].val     = src_val[g];
      assign src_if[g].seq_num = src_seq_num[g];
      assign src_if[g].target  = src_target[g];
      assign src_if[g].cause   = src_cause[g];
    end
  endgenerate

  //----------------------------------------------------------
  // Blocks
  //----------------------------------------------------------

  commit_tracker i_commit_tracker (
    .clk            (clk),
    .reset          (reset),
    .commit_val     (commit_val),
    .commit_seq_num (commit_seq_num),
    .head           (head)
  );

  squash_arb_chain i_squash_arb_chain (
    .arb  (src_if),
    .gnt  (gnt_if),
    .head (head)
  );

  squash_fsm i_squash_fsm (
    .clk              (clk),
    .reset            (reset),
    .gnt              (gnt_if),
    .head             (head),
    .commit_val       (commit_val),
    .commit_seq_num   (commit_seq_num),
    .redirect_val     (redirect_val),
    .redirect_seq_num (redirect_seq_num),
    .redirect_target  (redirect_target),
    .redirect_cause   (redirect_cause),
    .squash_busy      (squash_busy)
  );

endmodule

// ==== tests/squash_unit_tb.sv ====
//----------------------------------------------------------
// Testbench for the squash unit. Directed cases for oldest
// selection, drain, commit exit and wrap-around, then random
// traffic, all checked against a cycle model on every edge.
//----------------------------------------------------------

module squash_unit_tb
  import seq_pkg::*, squash_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  //----------------------------------------------------------
  // Run length and watchdog
  //----------------------------------------------------------

  localparam int N_RANDOM        = 400;
  localparam int N_DIRECTED      = 40;
  localparam int NUM_TEST_CYCLES = N_DIRECTED + N_RANDOM + 3;
  localparam int TIMEOUT_NS      = NUM_TEST_CYCLES * 10 + 500;

  logic                    clk;
  logic                    reset;
  logic                    src_val     [NUM_SQUASH_SRC];
  logic [SEQ_NUM_BITS-1:0] src_seq_num [NUM_SQUASH_SRC];
  logic [TARGET_BITS-1:0]  src_target  [NUM_SQUASH_SRC];
  logic [CAUSE_BITS-1:0]   src_cause   [NUM_SQUASH_SRC];
  logic                    commit_val;
  logic [SEQ_NUM_BITS-1:0] commit_seq_num;
  logic                    redirect_val;
  logic [SEQ_NUM_BITS-1:0] redirect_seq_num;
  logic [TARGET_BITS-1:0]  redirect_target;
  logic [CAUSE_BITS-1:0]   redirect_cause;
  logic                    squash_busy;

  // Model state, updated on each rising edge
  logic                    exp_redirect_val;
  logic                    exp_busy;
  logic                    exp_held_valid;
  logic [SEQ_NUM_BITS-1:0] exp_head;
  logic [SEQ_NUM_BITS-1:0] exp_held_seq;
  logic [TARGET_BITS-1:0]  exp_held_target;
  logic [CAUSE_BITS-1:0]   exp_held_cause;

  int num_checks = 0;
  int num_errors = 0;

  logic [15:0] lfsr_state = 16'd38343;

  tb_clock_gen i_tb_clock_gen (
    .clk   (clk),
    .reset (reset)
  );

  squash_unit i_squash_unit (
    .clk              (clk),
    .reset            (reset),
    .src_val          (src_val),
    .src_seq_num      (src_seq_num),
    .src_target       (src_target),
    .src_cause        (src_cause),
    .commit_val       (commit_val),
    .commit_seq_num   (commit_seq_num),
    .redirect_val     (redirect_val),
    .redirect_seq_num (redirect_seq_num),
    .redirect_target  (redirect_target),
    .redirect_cause   (redirect_cause),
    .squash_busy      (squash_busy)
  );

  //----------------------------------------------------------
  // Random bits and reference model
  //----------------------------------------------------------

  // Galois LFSR, one step per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int k = 0; k < n; k++) begin
      r = {r[30:0], lfsr_state[0]};
      lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 16'hB400) : (lfsr_state >> 1);
    end
    return r;
  endfunction

  // Smaller distance from head is older
  function automatic bit ref_older(input int a, input int b, input int h);
    int window;
    int dist_a;
    int dist_b;
    window = 1 << SEQ_NUM_BITS;
    dist_a = (a - h + window) % window;
    dist_b = (b - h + window) % window;
    return dist_a < dist_b;
  endfunction

  // Next-cycle outputs from the current inputs and model state
  function automatic void predict_next();
    logic                    w_val;
    logic [SEQ_NUM_BITS-1:0] w_seq;
    logic [TARGET_BITS-1:0]  w_target;
    logic [CAUSE_BITS-1:0]   w_cause;
    logic                    accept;
    w_val    = 1'b0;
    w_seq    = '0;
    w_target = '0;
    w_cause  = '0;
    // Oldest valid source, lowest index on a tie
    for (int i = 0; i < NUM_SQUASH_SRC; i++) begin
      if (src_val[i] && (!w_val || ref_older(src_seq_num[i], w_seq, exp_head))) begin
        w_val    = 1'b1;
        w_seq    = src_seq_num[i];
        w_target = src_target[i];
        w_cause  = src_cause[i];
      end
    end
    accept = w_val && (!exp_busy || ref_older(w_seq, exp_held_seq, exp_head));
    exp_redirect_val = accept;
    if (accept) begin
      exp_busy        = 1'b1;
      exp_held_valid  = 1'b1;
      exp_held_seq    = w_seq;
      exp_held_target = w_target;
      exp_held_cause  = w_cause;
    end else if (exp_busy && commit_val && (commit_seq_num == exp_held_seq)) begin
      exp_busy = 1'b0;
    end
    if (commit_val) begin
      exp_head = commit_seq_num + 1'b1;
    end
  endfunction

  //----------------------------------------------------------
  // Compare tasks
  //----------------------------------------------------------

  task automatic check_val(input string name, input logic got, input logic exp);
    num_checks++;
    if (got !== exp) begin
      num_errors++;
      $display("** Error: %s got 0x%0h expected 0x%0h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic check_seq(input string name, input logic [SEQ_NUM_BITS-1:0] got,
                           input logic [SEQ_NUM_BITS-1:0] exp);
    num_checks++;
    if (got !== exp) begin
      num_errors++;
      $display("** Error: %s got 0x%0h expected 0x%0h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic check_target(input string name, input logic [TARGET_BITS-1:0] got,
                              input logic [TARGET_BITS-1:0] exp);
    num_checks++;
    if (got !== exp) begin
      num_errors++;
      $display("** Error: %s got 0x%0h expected 0x%0h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic check_cause(input string name, input logic [CAUSE_BITS-1:0] got,
                             input logic [CAUSE_BITS-1:0] exp);
    num_checks++;
    if (got !== exp) begin
      num_errors++;
      $display("** Error: %s got 0x%0h expected 0x%0h at %0t", name, got, exp, $time);
    end
  endtask

  // Model step on the edge, compare once the DUT has settled
  initial begin : compare
    forever begin
      @(posedge clk);
      if (reset) begin
        exp_redirect_val = 1'b0;
        exp_busy         = 1'b0;
        exp_held_valid   = 1'b0;
        exp_head         = '0;
      end else begin
        predict_next();
      end
      #1;
      check_val("redirect_val", redirect_val, exp_redirect_val);
      check_val("squash_busy", squash_busy, exp_busy);
      check_seq("head", i_squash_unit.head, exp_head);
      // Payload is undefined until the first acceptance
      if (exp_held_valid) begin
        check_seq("redirect_seq_num", redirect_seq_num, exp_held_seq);
        check_target("redirect_target", redirect_target, exp_held_target);
        check_cause("redirect_cause", redirect_cause, exp_held_cause);
      end
    end
  end

  //----------------------------------------------------------
  // Stimulus helpers
  //----------------------------------------------------------

  task automatic clear_inputs();
    for (int i = 0; i < NUM_SQUASH_SRC; i++) begin
      src_val[i]     = 1'b0;
      src_seq_num[i] = '0;
      src_target[i]  = '0;
      src_cause[i]   = '0;
    end
    commit_val     = 1'b0;
    commit_seq_num = '0;
  endtask

  task automatic drive_src(input int idx, input logic [SEQ_NUM_BITS-1:0] seq,
                           input logic [TARGET_BITS-1:0] target,
                           input logic [CAUSE_BITS-1:0] cause);
    src_val[idx]     = 1'b1;
    src_seq_num[idx] = seq;
    src_target[idx]  = target;
    src_cause[idx]   = cause;
  endtask

  task automatic drive_commit(input logic [SEQ_NUM_BITS-1:0] seq);
    commit_val     = 1'b1;
    commit_seq_num = seq;
  endtask

  // Next falling edge with all inputs low
  task automatic next_cycle();
    @(negedge clk);
    clear_inputs();
  endtask

  //----------------------------------------------------------
  // Directed and random stimulus
  //----------------------------------------------------------

  initial begin : stimulus
    logic [CAUSE_BITS-1:0] cause;
    clear_inputs();
    @(negedge clk);
    while (reset !== 1'b0) @(negedge clk);
    repeat (2) next_cycle();

    // Oldest from idle, tie between 1 and 2 goes to 1
    drive_src(0, 6'd10, 32'h1000_0000, CAUSE_BRANCH);
    drive_src(1, 6'd5, 32'h1000_0100, CAUSE_BRANCH);
    drive_src(2, 6'd5, 32'h2000_0000, CAUSE_MEM_ORDER);
    next_cycle();

    // Older squash replaces the held one in drain
    drive_src(2, 6'd3, 32'h2000_0040, CAUSE_MEM_ORDER);
    next_cycle();
    // Younger squash is dropped
    drive_src(0, 6'd20, 32'h1000_0200, CAUSE_BRANCH);
    next_cycle();
    next_cycle();

    // Commit of the held number ends the drain
    drive_commit(6'd3);
    repeat (2) next_cycle();
    drive_src(1, 6'd8, 32'h1000_0300, CAUSE_BRANCH);
    next_cycle();
    drive_commit(6'd8);
    next_cycle();

    // Head near the top of the window
    drive_commit(6'd59);
    next_cycle();
    drive_src(0, 6'd2, 32'h3000_0000, CAUSE_BRANCH);
    drive_src(1, 6'd61, 32'h3000_0010, CAUSE_MEM_ORDER);
    drive_src(2, 6'd63, 32'h3000_0020, CAUSE_BRANCH);
    next_cycle();
    drive_src(0, 6'd60, 32'h3000_0030, CAUSE_MEM_ORDER);
    drive_src(2, 6'd1, 32'h3000_0040, CAUSE_BRANCH);
    next_cycle();
    drive_commit(6'd60);
    repeat (2) next_cycle();

    // Random notifications near head, commits that hit the held number
    for (int n = 0; n < N_RANDOM; n++) begin
      for (int i = 0; i < NUM_SQUASH_SRC; i++) begin
        if (rand_bits(2) == 0) begin
          cause = rand_bits(1) ? CAUSE_BRANCH : CAUSE_MEM_ORDER;
          drive_src(i, exp_head + rand_bits(4), rand_bits(32), cause);
        end
      end
      if (rand_bits(2) == 0) begin
        if (exp_busy && rand_bits(1)) begin
          drive_commit(exp_held_seq);
        end else begin
          drive_commit(exp_head + rand_bits(3));
        end
      end
      next_cycle();
    end

    repeat (3) next_cycle();
    $display("Checks run: %0d, errors: %0d", num_checks, num_errors);
    if (num_errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

  // Watchdog
  initial begin : watchdog
    #(TIMEOUT_NS * 1ns);
    $display("Timeout: stimulus did not finish within %0d ns", TIMEOUT_NS);
    $display("Checks run: %0d, errors: %0d", num_checks, num_errors);
    $display("RESULT: FAIL");
    $finish;
  end

endmodule

// ==== tests/tb_clock_gen.sv ====
//----------------------------------------------------------
// Testbench clock and reset. 10 ns clock, reset held high
// for the first 3 rising edges.
//----------------------------------------------------------

module tb_clock_gen (
  output logic clk,
  output logic reset
);

  timeunit 1ns;
  timeprecision 1ps;

  localparam int HALF_PERIOD_NS = 5;
  localparam int RESET_CYCLES   = 3;

  initial begin
    clk = 1'b0;
    forever #(HALF_PERIOD_NS) clk = ~clk;
  end

  // Released on a rising edge, seen low from the next one
  initial begin
    reset = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    reset <= 1'b0;
  end

endmodule
